//--- compile.f
design/ctr_pkg.sv
design/pattern_source.sv
design/trigger_detect.sv
design/updown_counter.sv
design/counter_host.sv
sim/counter_host_asserts.sv
sim/counter_host_tb.sv

//--- Makefile
SIM = obj_dir/counter_host_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module counter_host_tb -Mdir obj_dir -o counter_host_sim

run: compile
	./$(SIM) | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/counter_host_tb.sv
// --------------------
// Counter host testbench
// Directed and random tests against a cycle model
// --------------------
`timescale 1ns/100ps

module counter_host_tb;

    import ctr_pkg::*;

    localparam int random_cycles  = 20000;
    localparam int planned_cycles = 8 + 200 + random_cycles;   // Reset, directed, random

    logic                     clk;
    logic                     rst;
    logic                     count_enable;
    logic                     count_direction;
    logic                     load_counter;
    logic [counter_width-1:0] load_value;
    logic [counter_width-1:0] counter_value;
    logic                     counter_overflow;
    logic                     counter_underflow;
    logic                     counter_zero;

    // Reference model state
    logic [counter_width-1:0] m_count;
    logic [counter_width-1:0] m_value;
    logic                     m_ovf;
    logic                     m_unf;
    logic                     m_zero;
    logic [pattern_width-1:0] m_pat;
    logic [2:0]               m_sel;
    det_state_t               m_state;
    logic                     m_clear;   // Pending forced clear

    int error_count = 0;
    int check_count = 0;
    int clear_count = 0;
    int tests_ok    = 0;
    int tests_bad   = 0;

    counter_host i_counter_host (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count_direction   (count_direction),
        .load_counter      (load_counter),
        .load_value        (load_value),
        .counter_value     (counter_value),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow),
        .counter_zero      (counter_zero)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] pattern_byte(input logic [pattern_width-1:0] pat,
                                                input logic [2:0] sel);
        case (sel)
            3'd0:    return pat[7:0];
            3'd1:    return pat[15:8];
            3'd2:    return pat[23:16];
            3'd3:    return pat[27:20];
            3'd4:    return pat[7:0] ^ pat[15:8];
            3'd5:    return pat[23:16] ^ pat[7:0];
            3'd6:    return pat[27:20] ^ pat[15:8];
            default: return pat[27:20] ^ pat[7:0];
        endcase
    endfunction

    function automatic void model_reset();
        m_count = '0;
        m_value = '0;
        m_ovf   = 1'b0;
        m_unf   = 1'b0;
        m_zero  = 1'b1;
        m_pat   = pattern_seed;
        m_sel   = 3'd0;
        m_state = det_idle;
        m_clear = 1'b0;
    endfunction

    // One clock edge of the whole subsystem, all terms taken from the old state
    function automatic void model_step(input logic en, input logic dir, input logic ld,
                                       input logic [counter_width-1:0] val);
        logic [7:0] seen;
        logic       fire;
        det_state_t state_new;
        seen      = pattern_byte(m_pat, m_sel);
        fire      = 1'b0;
        state_new = det_idle;
        if (m_state == det_idle) begin
            if (seen == trigger_byte_1) begin
                state_new = det_armed;
            end
        end else if (seen == trigger_byte_2) begin
            fire = 1'b1;
        end else if (seen == trigger_byte_1) begin
            state_new = det_armed;
        end
        if (en) begin
            if (m_ovf || m_unf || m_count[3:0] == 4'h0) begin
                m_sel = m_sel + 3'd1;
            end
            m_pat = {m_pat[pattern_width-2:0], m_pat[27] ^ m_pat[22] ^ m_pat[16] ^ m_pat[3]};
        end
        m_value = m_clear ? '0 : m_count;
        if (m_clear) begin
            m_count = '0;
            m_ovf   = 1'b0;
            m_unf   = 1'b0;
            m_zero  = 1'b1;
            clear_count++;
        end else if (ld) begin
            m_count = val;
            m_zero  = (val == '0);
            m_ovf   = 1'b0;
            m_unf   = 1'b0;
        end else if (en && !dir) begin
            m_ovf   = (m_count == counter_width'(count_max - 1));
            m_zero  = m_ovf || (m_count == counter_width'(count_max - 2));
            m_count = m_ovf ? '0 : m_count + counter_width'(1);
        end else if (en) begin
            m_unf   = (m_count == '0);
            m_zero  = (m_count == counter_width'(1));
            m_count = m_unf ? counter_width'(count_max - 1) : m_count - counter_width'(1);
        end
        m_state = state_new;
        m_clear = fire;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t ns",
                     name, actual, expected, $time);
            error_count++;
        end
    endtask

    // Inputs change 1 ns after the edge and are sampled on the next one
    task automatic apply(input logic en, input logic dir, input logic ld,
                         input logic [counter_width-1:0] val);
        count_enable    = en;
        count_direction = dir;
        load_counter    = ld;
        load_value      = val;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_ok++;
            $display("[%0t ns] %s: ok", $time, name);
        end else begin
            tests_bad++;
            $display("[%0t ns] %s: %0d errors", $time, name, error_count - errors_before);
        end
    endtask

    // Model follows every edge, outputs compared half a cycle later
    initial begin
        model_reset();
        forever begin
            @(posedge clk);
            if (rst) begin
                model_reset();
            end else begin
                model_step(count_enable, count_direction, load_counter, load_value);
            end
            @(negedge clk);
            check_value("counter_value", 32'(counter_value), 32'(m_value));
            check_value("counter_overflow", 32'(counter_overflow), 32'(m_ovf));
            check_value("counter_underflow", 32'(counter_underflow), 32'(m_unf));
            check_value("counter_zero", 32'(counter_zero), 32'(m_zero));
        end
    end

    initial begin
        #(planned_cycles * 4 + 2000);
        $display("timeout: run did not finish within %0d planned cycles", planned_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        int                       base;
        int                       clears0;
        int                       edge_val;
        logic                     dir;
        logic [counter_width-1:0] val;
        logic [counter_width-1:0] loads [5];
        void'($urandom(8));
        rst             = 1'b1;
        count_enable    = 1'b0;
        count_direction = 1'b0;
        load_counter    = 1'b0;
        load_value      = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        base = error_count;
        check_value("counter_value", 32'(counter_value), 32'h0);
        check_value("counter_zero", 32'(counter_zero), 32'h1);
        check_value("counter_overflow", 32'(counter_overflow), 32'h0);
        check_value("counter_underflow", 32'(counter_underflow), 32'h0);
        finish_test("reset values", base);

        // Directed checks only hold while no forced clear has landed
        base    = error_count;
        clears0 = clear_count;
        loads   = '{12'd0, 12'd5, 12'd2047, 12'd1234, 12'd0};
        foreach (loads[i]) begin
            apply(1'b0, 1'b0, 1'b1, loads[i]);
            apply(1'b0, 1'b0, 1'b0, '0);
            if (clear_count == clears0) begin
                check_value("counter_value", 32'(counter_value), 32'(loads[i]));
                check_value("counter_zero", 32'(counter_zero), 32'(loads[i] == '0));
            end
        end
        finish_test("loads", base);

        base    = error_count;
        clears0 = clear_count;
        apply(1'b0, 1'b0, 1'b1, 12'd2045);
        apply(1'b1, 1'b0, 1'b0, '0);
        apply(1'b1, 1'b0, 1'b0, '0);
        apply(1'b1, 1'b0, 1'b0, '0);   // Wrap edge
        if (clear_count == clears0) begin
            check_value("counter_value", 32'(counter_value), 32'd2047);
            check_value("counter_overflow", 32'(counter_overflow), 32'h1);
            check_value("counter_zero", 32'(counter_zero), 32'h1);
        end
        apply(1'b1, 1'b0, 1'b0, '0);
        if (clear_count == clears0) begin
            check_value("counter_value", 32'(counter_value), 32'd0);
            check_value("counter_overflow", 32'(counter_overflow), 32'h0);
        end
        finish_test("count up wrap", base);

        base    = error_count;
        clears0 = clear_count;
        apply(1'b0, 1'b1, 1'b1, 12'd2);
        apply(1'b1, 1'b1, 1'b0, '0);
        apply(1'b1, 1'b1, 1'b0, '0);
        if (clear_count == clears0) begin
            check_value("counter_zero", 32'(counter_zero), 32'h1);
            check_value("counter_underflow", 32'(counter_underflow), 32'h0);
        end
        apply(1'b1, 1'b1, 1'b0, '0);   // 0 down to 2047
        if (clear_count == clears0) begin
            check_value("counter_value", 32'(counter_value), 32'd0);
            check_value("counter_underflow", 32'(counter_underflow), 32'h1);
            check_value("counter_zero", 32'(counter_zero), 32'h0);
        end
        apply(1'b1, 1'b1, 1'b0, '0);
        if (clear_count == clears0) begin
            check_value("counter_value", 32'(counter_value), 32'd2047);
            check_value("counter_underflow", 32'(counter_underflow), 32'h0);
        end
        finish_test("count down wrap", base);

        base    = error_count;
        clears0 = clear_count;
        dir     = 1'b0;
        repeat (random_cycles) begin
            if ($urandom % 16 == 0) begin
                dir = ~dir;   // Long runs one way reach the wrap points
            end
            if ($urandom % 40 == 0) begin
                edge_val = $urandom % 4;
                if ($urandom % 2 == 0) begin
                    val = counter_width'($urandom % count_max);
                end else if ($urandom % 2 == 0) begin
                    val = counter_width'(edge_val);
                end else begin
                    val = counter_width'(count_max - 1 - edge_val);
                end
                apply(1'b0, dir, 1'b1, val);
            end else begin
                apply(($urandom % 8) != 0, dir, 1'b0, '0);
            end
        end
        apply(1'b0, 1'b0, 1'b0, '0);
        finish_test("random mix", base);

        $display("summary: %0d tests ok, %0d tests with errors, %0d checks, %0d mismatches, %0d clears",
                 tests_ok, tests_bad, check_count, error_count, clear_count - clears0);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim/counter_host_asserts.sv
// --------------------
// Counter host assertions
// Wrap flags and forced clear pulse at the counter
// --------------------
`timescale 1ns/100ps

module counter_host_asserts (
    input logic                              clk,
    input logic                              rst,
    input logic                              force_clear,   // Pulse from trigger_detect
    input logic [ctr_pkg::counter_width-1:0] count,
    input logic                              counter_overflow,
    input logic                              counter_underflow
);

    import ctr_pkg::*;

    // A fresh wrap flag lands with the count at the far end
    wrap_flag_matches_count: assert property (
        @(posedge clk) disable iff (rst)
        (!$rose(counter_overflow) || (count == '0)) &&
        (!$rose(counter_underflow) || (count == counter_width'(count_max - 1)))
    ) else $error("wrap flag raised without the count wrapping");

    // Detector returns to idle with the pulse
    clear_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        force_clear |=> !force_clear
    ) else $error("force_clear held for more than one cycle");

    clear_zeroes_count: assert property (
        @(posedge clk) disable iff (rst)
        force_clear |=> (count == '0)
    ) else $error("count not zero after force_clear");

endmodule

bind updown_counter counter_host_asserts i_counter_host_asserts (
    .clk               (clk),
    .rst               (rst),
    .force_clear       (force_clear),
    .count             (count),
    .counter_overflow  (counter_overflow),
    .counter_underflow (counter_underflow)
);

//--- design/counter_host.sv
// --------------------
// Counter host top
// Counter, pattern source and trigger detector
// --------------------
`timescale 1ns/100ps

module counter_host (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              count_enable,
    input  logic                              count_direction,
    input  logic                              load_counter,
    input  logic [ctr_pkg::counter_width-1:0] load_value,
    output logic [ctr_pkg::counter_width-1:0] counter_value,
    output logic                              counter_overflow,
    output logic                              counter_underflow,
    output logic                              counter_zero
);

    import ctr_pkg::*;

    logic [counter_width-1:0] count;
    logic [7:0]               mon_byte;
    logic                     force_clear;

    updown_counter i_updown_counter (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count_direction   (count_direction),
        .load_counter      (load_counter),
        .load_value        (load_value),
        .force_clear       (force_clear),
        .count             (count),
        .counter_value     (counter_value),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow),
        .counter_zero      (counter_zero)
    );

    // Pattern advances only while counting
    pattern_source i_pattern_source (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count             (count),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow),
        .mon_byte          (mon_byte)
    );

    trigger_detect i_trigger_detect (
        .clk         (clk),
        .rst         (rst),
        .mon_byte    (mon_byte),
        .force_clear (force_clear)
    );

endmodule

//--- design/updown_counter.sv
// --------------------
// Up/down counter
// Loadable, wraps at count_max, with flags and lagged copy
// --------------------
`timescale 1ns/100ps

module updown_counter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              count_enable,
    input  logic                              count_direction,   // 0 up, 1 down
    input  logic                              load_counter,
    input  logic [ctr_pkg::counter_width-1:0] load_value,
    input  logic                              force_clear,
    output logic [ctr_pkg::counter_width-1:0] count,
    output logic [ctr_pkg::counter_width-1:0] counter_value,
    output logic                              counter_overflow,
    output logic                              counter_underflow,
    output logic                              counter_zero
);

    import ctr_pkg::*;

    logic at_top;
    logic at_bottom;

    assign at_top    = (count == counter_width'(count_max - 1));
    assign at_bottom = (count == '0);

    // Priority is forced clear, then load, then count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count             <= '0;
            counter_overflow  <= 1'b0;
            counter_underflow <= 1'b0;
            counter_zero      <= 1'b1;
        end else if (force_clear) begin
            count             <= '0;
            counter_overflow  <= 1'b0;
            counter_underflow <= 1'b0;
            counter_zero      <= 1'b1;
        end else if (load_counter) begin
            count             <= load_value;
            counter_zero      <= (load_value == '0);
            counter_overflow  <= 1'b0;
            counter_underflow <= 1'b0;
        end else if (count_enable) begin
            if (count_direction) begin
                // Counting down
                if (at_bottom) begin
                    count             <= counter_width'(count_max - 1);
                    counter_underflow <= 1'b1;
                    counter_zero      <= 1'b0;
                end else begin
                    count             <= count - 1'b1;
                    counter_underflow <= 1'b0;
                    counter_zero      <= (count == counter_width'(1));
                end
            end else begin
                // Counting up
                if (at_top) begin
                    count            <= '0;
                    counter_overflow <= 1'b1;
                    counter_zero     <= 1'b1;
                end else begin
                    count            <= count + 1'b1;
                    counter_overflow <= 1'b0;
                    counter_zero     <= (count == counter_width'(count_max - 2));
                end
            end
        end
    end

    // Output copy, one cycle behind count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter_value <= '0;
        end else if (force_clear) begin
            counter_value <= '0;      // Cleared on the same edge as count
        end else begin
            counter_value <= count;
        end
    end

endmodule

//--- design/trigger_detect.sv
// --------------------
// Trigger pair detector
// Pulses force_clear after the two-byte sequence
// --------------------
`timescale 1ns/100ps

module trigger_detect (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] mon_byte,
    output logic       force_clear
);

    import ctr_pkg::*;

    det_state_t state;
    det_state_t state_next;
    logic       clear_next;

    always_comb begin
        state_next = det_idle;
        clear_next = 1'b0;
        case (state)
            det_idle: begin
                if (mon_byte == trigger_byte_1) begin
                    state_next = det_armed;
                end
            end
            det_armed: begin
                if (mon_byte == trigger_byte_2) begin
                    clear_next = 1'b1;         // Pair complete
                end else if (mon_byte == trigger_byte_1) begin
                    state_next = det_armed;    // Repeated first byte keeps us armed
                end
            end
            default: state_next = det_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= det_idle;
            force_clear <= 1'b0;
        end else begin
            state       <= state_next;
            force_clear <= clear_next;        // One-cycle pulse
        end
    end

endmodule

//--- design/pattern_source.sv
// --------------------
// Pattern source
// Feedback shift pattern with byte select for the detector
// --------------------
`timescale 1ns/100ps

module pattern_source (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             count_enable,
    input  logic [ctr_pkg::counter_width-1:0] count,
    input  logic                             counter_overflow,
    input  logic                             counter_underflow,
    output logic [7:0]                       mon_byte
);

    import ctr_pkg::*;

    logic [pattern_width-1:0] pattern_reg;
    logic [2:0]               byte_sel;
    logic                     feedback_bit;
    logic                     sel_advance;

    // Taps at 27, 22, 16 and 3
    assign feedback_bit = pattern_reg[27] ^ pattern_reg[22] ^ pattern_reg[16] ^ pattern_reg[3];

    // Step the selector on a wrap or every 16 counts
    assign sel_advance = counter_overflow || counter_underflow || (count[3:0] == 4'h0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern_reg <= pattern_seed;
            byte_sel    <= 3'd0;
        end else if (count_enable) begin
            pattern_reg <= {pattern_reg[pattern_width-2:0], feedback_bit};
            if (sel_advance) begin
                byte_sel <= byte_sel + 3'd1;
            end
        end
    end

    // Monitored byte, plain slices then XOR mixes
    always_comb begin
        case (byte_sel)
            3'd0:    mon_byte = pattern_reg[7:0];
            3'd1:    mon_byte = pattern_reg[15:8];
            3'd2:    mon_byte = pattern_reg[23:16];
            3'd3:    mon_byte = pattern_reg[27:20];
            3'd4:    mon_byte = pattern_reg[7:0] ^ pattern_reg[15:8];
            3'd5:    mon_byte = pattern_reg[23:16] ^ pattern_reg[7:0];
            3'd6:    mon_byte = pattern_reg[27:20] ^ pattern_reg[15:8];
            default: mon_byte = pattern_reg[27:20] ^ pattern_reg[7:0];   // Index 7
        endcase
    end

endmodule

//--- design/ctr_pkg.sv
// --------------------
// Counter host shared definitions
// Widths, wrap limit, seed and trigger bytes
// --------------------
package ctr_pkg;

    // Counter sizing
    localparam int counter_width = 12;
    localparam int count_max     = 2048;   // Count runs 0 .. count_max-1

    // Pattern generator
    localparam int pattern_width = 28;
    localparam logic [pattern_width-1:0] pattern_seed = 28'hFEEDBEE;

    // Sequence detector triggers, in order of arrival
    localparam logic [7:0] trigger_byte_1 = 8'hAA;
    localparam logic [7:0] trigger_byte_2 = 8'h55;

    // Detector FSM states
    typedef enum logic {
        det_idle  = 1'b0,
        det_armed = 1'b1
    } det_state_t;

endpackage
